/* hw/pcie_rx_pkg.sv */
`default_nettype none

package pcie_rx_pkg;

    localparam int FLOW_IDX_WIDTH = 8;
    localparam int MAX_NB_FLOWS = 256;
    localparam int APP_IDX_WIDTH = 4;
    localparam int PKT_SIZE_WIDTH = 16;

    // Each packet queue owns one 4 KB page of the MMIO space
    localparam int MMIO_ADDR_WIDTH = 26;
    localparam int QUEUE_PAGE_LSB = 12;
    localparam int REG_SIZE_BYTES = 4;
    localparam int HEAD_REG_IDX = 1;

    localparam logic [31:0] CTRL_ADDR = 32'h0;
    localparam logic [31:0] IGNORED_CNT_ADDR = 32'h4;
    localparam logic [31:0] HEAD_UPD_CNT_ADDR = 32'h8;

    localparam int SW_RESET_BIT = 27;
    localparam int DISABLE_BIT = 0;

    typedef struct packed {
        logic [MMIO_ADDR_WIDTH-1:0] addr;
        logic [63:0]                byte_en;
    } mmio_wr_t;

    typedef struct packed {
        logic [APP_IDX_WIDTH-1:0]  dsc_queue_id;
        logic [FLOW_IDX_WIDTH-1:0] pkt_queue_id;
        logic [PKT_SIZE_WIDTH-1:0] size;
    } pkt_meta_t;

    typedef struct packed {
        logic [APP_IDX_WIDTH-1:0]  dsc_queue_id;
        logic [FLOW_IDX_WIDTH-1:0] pkt_queue_id;
        logic [PKT_SIZE_WIDTH-1:0] size;
        logic                      descriptor_only;
        logic                      needs_dsc;
    } pkt_meta_with_queues_t;

endpackage

`default_nettype wire

/* hw/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  wire                   pcie_clk,
    input  wire                   pcie_reset_n,
    input  wire  [DATA_WIDTH-1:0] in_data,
    input  wire                   in_valid,
    output logic                  in_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  out_valid,
    input  wire                   out_ready,
    output logic [31:0]           occup
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [31:0]           count;
    logic                  push;
    logic                  pop;

    // Pointers wrap explicitly so that DEPTH need not be a power of two
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push = in_valid & in_ready;
    assign pop = out_valid & out_ready;
    assign in_ready = count < 32'(DEPTH);
    assign out_valid = count != 32'd0;
    assign out_data = mem[rd_ptr];
    assign occup = count;

    always_ff @(posedge pcie_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + 32'(push) - 32'(pop);
        end
    end

    // Producers throttle on occup instead of in_ready, so a push into a full FIFO would be lost
    a_no_push_when_full: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n) in_valid |-> in_ready
    );

endmodule

`default_nettype wire

/* hw/head_upd_monitor.sv */
`default_nettype none

module head_upd_monitor #(
    parameter int HEAD_UPD_QUEUE_LEN = 128
) (
    input  wire                                     pcie_clk,
    input  wire                                     pcie_reset_n,
    input  wire                                     sw_reset,
    input  wire                                     mmio_write,
    input  var pcie_rx_pkg::mmio_wr_t               mmio_wr,
    input  wire  [31:0]                             fifo_occup,
    output logic [pcie_rx_pkg::FLOW_IDX_WIDTH-1:0]  upd_queue_id,
    output logic                                    upd_valid,
    output logic [31:0]                             ignored_cnt
);

    localparam int PAGE_IDX_WIDTH = pcie_rx_pkg::MMIO_ADDR_WIDTH - pcie_rx_pkg::QUEUE_PAGE_LSB;
    localparam int BE_LSB = pcie_rx_pkg::HEAD_REG_IDX * pcie_rx_pkg::REG_SIZE_BYTES;

    logic [PAGE_IDX_WIDTH-1:0] page_idx;
    logic                      head_upd;
    logic                      almost_full;

    // The full page index is kept so that writes beyond the last queue are rejected
    assign page_idx = mmio_wr.addr[pcie_rx_pkg::QUEUE_PAGE_LSB +: PAGE_IDX_WIDTH];

    assign head_upd = mmio_write
        && (page_idx < PAGE_IDX_WIDTH'(pcie_rx_pkg::MAX_NB_FLOWS))
        && (mmio_wr.byte_en[BE_LSB +: pcie_rx_pkg::REG_SIZE_BYTES] == '1);

    // Leaves room for the pushes already in flight
    assign almost_full = fifo_occup > 32'(HEAD_UPD_QUEUE_LEN - 4);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            upd_valid <= 1'b0;
        end else begin
            upd_valid <= head_upd & !almost_full;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (head_upd & !almost_full) begin
            upd_queue_id <= page_idx[pcie_rx_pkg::FLOW_IDX_WIDTH-1:0];
        end
    end

    // Dropped updates are counted so software can see that it writes heads too often
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n || sw_reset) begin
            ignored_cnt <= '0;
        end else if (head_upd & almost_full) begin
            ignored_cnt <= ignored_cnt + 32'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/rx_meta_merger.sv */
`default_nettype none

module rx_meta_merger #(
    parameter int IN_QUEUE_LEN = 8
) (
    input  wire                                     pcie_clk,
    input  wire                                     pcie_reset_n,
    input  wire                                     sw_reset,
    input  wire  [pcie_rx_pkg::FLOW_IDX_WIDTH-1:0]  upd_queue_id,
    input  wire                                     upd_valid,
    output logic                                    upd_ready,
    input  var pcie_rx_pkg::pkt_meta_t              meta_in,
    input  wire                                     meta_in_valid,
    output logic                                    meta_in_ready,
    output pcie_rx_pkg::pkt_meta_with_queues_t      rec,
    output logic                                    rec_valid,
    input  wire  [31:0]                             out_occup,
    output logic [31:0]                             head_upd_cnt
);

    pcie_rx_pkg::pkt_meta_with_queues_t next_rec;

    logic accept_en;
    logic almost_full;
    logic merge;
    logic upd_take;
    logic meta_take;

    // Half the output FIFO stays free for records still in the register stage
    assign almost_full = out_occup > 32'(IN_QUEUE_LEN / 2);

    // Head updates win, but a packet for the same queue rides along with its update
    always_comb begin
        upd_ready = 1'b0;
        meta_in_ready = 1'b0;
        merge = 1'b0;
        if (accept_en && !almost_full) begin
            upd_ready = 1'b1;
            if (upd_valid) begin
                merge = meta_in_valid && (meta_in.pkt_queue_id == upd_queue_id);
                meta_in_ready = merge;
            end else begin
                meta_in_ready = 1'b1;
            end
        end
    end

    assign upd_take = upd_valid & upd_ready;
    assign meta_take = meta_in_valid & meta_in_ready;

    always_comb begin
        next_rec.dsc_queue_id = '0;
        next_rec.pkt_queue_id = upd_queue_id;
        next_rec.size = '0;
        next_rec.descriptor_only = 1'b1;
        next_rec.needs_dsc = 1'b0;
        if (meta_take) begin
            next_rec.dsc_queue_id = meta_in.dsc_queue_id;
            next_rec.pkt_queue_id = meta_in.pkt_queue_id;
            next_rec.size = meta_in.size;
            next_rec.descriptor_only = 1'b0;
            next_rec.needs_dsc = merge;
        end
    end

    // The input side opens one cycle after reset is released
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            accept_en <= 1'b0;
            rec_valid <= 1'b0;
        end else begin
            accept_en <= 1'b1;
            rec_valid <= upd_take | meta_take;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (upd_take | meta_take) begin
            rec <= next_rec;
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n || sw_reset) begin
            head_upd_cnt <= '0;
        end else if (upd_take) begin
            head_upd_cnt <= head_upd_cnt + 32'd1;
        end
    end

    // The almost full threshold must keep the register stage from overrunning the FIFO
    a_no_rec_into_full: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
        rec_valid |-> (out_occup < 32'(IN_QUEUE_LEN))
    );

endmodule

`default_nettype wire

/* hw/ctrl_regs.sv */
`default_nettype none

module ctrl_regs (
    input  wire         pcie_clk,
    input  wire         pcie_reset_n,
    input  wire  [31:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  wire  [31:0] ignored_cnt,
    input  wire  [31:0] head_upd_cnt,
    output logic        disable_pcie,
    output logic        sw_reset
);

    logic [31:0] ctrl_reg;
    logic        sw_reset_r1;
    logic        apb_wr;

    assign pready = 1'b1;
    assign apb_wr = psel & penable & pwrite;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            ctrl_reg <= '0;
        end else if (apb_wr && (paddr == pcie_rx_pkg::CTRL_ADDR)) begin
            ctrl_reg <= pwdata;
        end
    end

    assign disable_pcie = ctrl_reg[pcie_rx_pkg::DISABLE_BIT];

    // Software sets and later clears this bit, the statistics stay cleared while it is high
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            sw_reset_r1 <= 1'b0;
            sw_reset <= 1'b0;
        end else begin
            sw_reset_r1 <= ctrl_reg[pcie_rx_pkg::SW_RESET_BIT];
            sw_reset <= sw_reset_r1;
        end
    end

    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                pcie_rx_pkg::CTRL_ADDR:         prdata = ctrl_reg;
                pcie_rx_pkg::IGNORED_CNT_ADDR:  prdata = ignored_cnt;
                pcie_rx_pkg::HEAD_UPD_CNT_ADDR: prdata = head_upd_cnt;
                default:                        prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/pcie_rx_top.sv */
`default_nettype none

module pcie_rx_top #(
    parameter int HEAD_UPD_QUEUE_LEN = 128,
    parameter int IN_QUEUE_LEN = 8
) (
    input  wire                                 pcie_clk,
    input  wire                                 pcie_reset_n,
    input  wire                                 mmio_write,
    input  var pcie_rx_pkg::mmio_wr_t           mmio_wr,
    input  var pcie_rx_pkg::pkt_meta_t          meta_in,
    input  wire                                 meta_in_valid,
    output logic                                meta_in_ready,
    output pcie_rx_pkg::pkt_meta_with_queues_t  rec_out,
    output logic                                rec_out_valid,
    input  wire                                 rec_out_ready,
    input  wire  [31:0]                         paddr,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                disable_pcie
);

    logic [pcie_rx_pkg::FLOW_IDX_WIDTH-1:0] head_in_data;
    logic                                   head_in_valid;
    logic [pcie_rx_pkg::FLOW_IDX_WIDTH-1:0] head_out_data;
    logic                                   head_out_valid;
    logic                                   head_out_ready;
    logic [31:0]                            head_occup;

    pcie_rx_pkg::pkt_meta_with_queues_t     rec_in_data;
    logic                                   rec_in_valid;
    logic [31:0]                            rec_occup;

    logic [31:0]                            ignored_cnt;
    logic [31:0]                            head_upd_cnt;
    logic                                   sw_reset;

    head_upd_monitor #(
        .HEAD_UPD_QUEUE_LEN (HEAD_UPD_QUEUE_LEN)
    ) head_upd_monitor_inst (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .sw_reset     (sw_reset),
        .mmio_write   (mmio_write),
        .mmio_wr      (mmio_wr),
        .fifo_occup   (head_occup),
        .upd_queue_id (head_in_data),
        .upd_valid    (head_in_valid),
        .ignored_cnt  (ignored_cnt)
    );

    sync_fifo #(
        .DATA_WIDTH (pcie_rx_pkg::FLOW_IDX_WIDTH),
        .DEPTH      (HEAD_UPD_QUEUE_LEN)
    ) head_upd_queue (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .in_data      (head_in_data),
        .in_valid     (head_in_valid),
        .in_ready     (),
        .out_data     (head_out_data),
        .out_valid    (head_out_valid),
        .out_ready    (head_out_ready),
        .occup        (head_occup)
    );

    rx_meta_merger #(
        .IN_QUEUE_LEN (IN_QUEUE_LEN)
    ) rx_meta_merger_inst (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .sw_reset      (sw_reset),
        .upd_queue_id  (head_out_data),
        .upd_valid     (head_out_valid),
        .upd_ready     (head_out_ready),
        .meta_in       (meta_in),
        .meta_in_valid (meta_in_valid),
        .meta_in_ready (meta_in_ready),
        .rec           (rec_in_data),
        .rec_valid     (rec_in_valid),
        .out_occup     (rec_occup),
        .head_upd_cnt  (head_upd_cnt)
    );

    sync_fifo #(
        .DATA_WIDTH ($bits(pcie_rx_pkg::pkt_meta_with_queues_t)),
        .DEPTH      (IN_QUEUE_LEN)
    ) in_queue (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .in_data      (rec_in_data),
        .in_valid     (rec_in_valid),
        .in_ready     (),
        .out_data     (rec_out),
        .out_valid    (rec_out_valid),
        .out_ready    (rec_out_ready),
        .occup        (rec_occup)
    );

    ctrl_regs ctrl_regs_inst (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .ignored_cnt  (ignored_cnt),
        .head_upd_cnt (head_upd_cnt),
        .disable_pcie (disable_pcie),
        .sw_reset     (sw_reset)
    );

endmodule

`default_nettype wire

/* test/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] stim_state = 32'h98ee;

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
endfunction

function automatic pcie_rx_pkg::pkt_meta_t random_meta();
    pcie_rx_pkg::pkt_meta_t meta;
    logic [31:0] r;
    r = next_rand();
    meta.dsc_queue_id = r[3:0];
    meta.pkt_queue_id = r[11:4];
    meta.size = r[27:12];
    return meta;
endfunction

// A head write only counts for a real queue with every byte of its head slot enabled
function automatic logic head_write_counts(input int unsigned page, input logic [63:0] be);
    logic [3:0] slot;
    slot = be[pcie_rx_pkg::HEAD_REG_IDX * pcie_rx_pkg::REG_SIZE_BYTES +: 4];
    return (page < 256) && (slot == 4'hF);
endfunction

// A lone head update is a descriptor-only record, a packet keeps its own fields
function automatic pcie_rx_pkg::pkt_meta_with_queues_t expect_record(
    input logic                                   is_head,
    input logic                                   merged,
    input logic [pcie_rx_pkg::FLOW_IDX_WIDTH-1:0] head_queue,
    input pcie_rx_pkg::pkt_meta_t                 meta
);
    pcie_rx_pkg::pkt_meta_with_queues_t rec;
    if (is_head && !merged) begin
        rec.dsc_queue_id = '0;
        rec.pkt_queue_id = head_queue;
        rec.size = '0;
        rec.descriptor_only = 1'b1;
        rec.needs_dsc = 1'b0;
    end else begin
        rec.dsc_queue_id = meta.dsc_queue_id;
        rec.pkt_queue_id = meta.pkt_queue_id;
        rec.size = meta.size;
        rec.descriptor_only = 1'b0;
        rec.needs_dsc = is_head && merged;
    end
    return rec;
endfunction

task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge pcie_clk);
    penable = 1'b1;
    @(negedge pcie_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge pcie_clk);
    penable = 1'b1;
    @(posedge pcie_clk);
    data = prdata;
    @(negedge pcie_clk);
    psel = 1'b0;
    penable = 1'b0;
endtask

// One write per cycle when called back to back
task automatic head_write(input int unsigned page, input logic [63:0] be);
    logic [31:0] full_addr;
    full_addr = page << pcie_rx_pkg::QUEUE_PAGE_LSB;
    mmio_wr.addr = full_addr[pcie_rx_pkg::MMIO_ADDR_WIDTH-1:0];
    mmio_wr.byte_en = be;
    mmio_write = 1'b1;
    @(negedge pcie_clk);
    mmio_write = 1'b0;
endtask

task automatic wait_meta_accept();
    do begin
        @(posedge pcie_clk);
    end while (!meta_in_ready);
    @(negedge pcie_clk);
    meta_in_valid = 1'b0;
endtask

task automatic send_meta(input pcie_rx_pkg::pkt_meta_t meta);
    meta_in = meta;
    meta_in_valid = 1'b1;
    wait_meta_accept();
endtask

`endif

/* test/tb_top.sv */
`default_nettype none

module tb_top;

    localparam int HEAD_UPD_QUEUE_LEN = 128;
    localparam int IN_QUEUE_LEN = 8;
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NB_META = 40;
    localparam int NB_FLOOD = 140;
    localparam int FILL_RECORDS = IN_QUEUE_LEN / 2 + 1;
    // The head FIFO settles two entries above its threshold, and the output side holds half
    // its depth plus the two records that were still in the merger register stage
    localparam int FLOOD_KEPT = (HEAD_UPD_QUEUE_LEN - 4 + 2) + (IN_QUEUE_LEN / 2 + 2);
    localparam int NB_ITEMS = NB_META + 3 + 2 * (FILL_RECORDS + 1) + NB_FLOOD + 8;
    localparam int TIMEOUT_CYCLES = 200 * NB_ITEMS;
    localparam int HEAD_LSB = pcie_rx_pkg::HEAD_REG_IDX * pcie_rx_pkg::REG_SIZE_BYTES;
    localparam logic [63:0] HEAD_BE = 64'hF << HEAD_LSB;
    localparam logic [63:0] PARTIAL_BE = 64'h7 << HEAD_LSB;

    logic                               pcie_clk;
    logic                               pcie_reset_n;
    logic                               mmio_write;
    pcie_rx_pkg::mmio_wr_t              mmio_wr;
    pcie_rx_pkg::pkt_meta_t             meta_in;
    logic                               meta_in_valid;
    logic                               meta_in_ready;
    pcie_rx_pkg::pkt_meta_with_queues_t rec_out;
    logic                               rec_out_valid;
    logic                               rec_out_ready;
    logic [31:0]                        paddr;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [31:0]                        pwdata;
    logic [31:0]                        prdata;
    logic                               pready;
    logic                               disable_pcie;

    pcie_rx_pkg::pkt_meta_with_queues_t expected_q[$];
    string                              test_name;
    int                                 head_records;
    logic                               random_stall;
    logic [31:0]                        stall_state = 32'h98ee;

    `include "tb_model.svh"

    pcie_rx_top #(
        .HEAD_UPD_QUEUE_LEN (HEAD_UPD_QUEUE_LEN),
        .IN_QUEUE_LEN       (IN_QUEUE_LEN)
    ) dut0 (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .mmio_write    (mmio_write),
        .mmio_wr       (mmio_wr),
        .meta_in       (meta_in),
        .meta_in_valid (meta_in_valid),
        .meta_in_ready (meta_in_ready),
        .rec_out       (rec_out),
        .rec_out_valid (rec_out_valid),
        .rec_out_ready (rec_out_ready),
        .paddr         (paddr),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .disable_pcie  (disable_pcie)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("Mismatch in %s, %s: expected %0h, actual %0h",
                                    test_name, what, expected, actual));
        end
    endtask

    task automatic add_expected(input pcie_rx_pkg::pkt_meta_with_queues_t rec);
        expected_q.push_back(rec);
        if (rec.descriptor_only || rec.needs_dsc) begin
            head_records++;
        end
    endtask

    task automatic issue_head(input int unsigned page, input logic [63:0] be);
        if (head_write_counts(page, be)) begin
            add_expected(expect_record(1'b1, 1'b0, page[7:0], '0));
        end
        head_write(page, be);
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0) begin
            @(negedge pcie_clk);
        end
        repeat (4) @(negedge pcie_clk);
    endtask

    initial begin
        pcie_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            pcie_clk = ~pcie_clk;
        end
    end

    always @(negedge pcie_clk) begin
        if (random_stall) begin
            stall_state = xorshift32(stall_state);
            rec_out_ready = stall_state[1:0] != 2'b00;
        end
    end

    always @(posedge pcie_clk) begin
        pcie_rx_pkg::pkt_meta_with_queues_t want;
        if (pcie_reset_n && rec_out_valid && rec_out_ready) begin
            assert (expected_q.size() != 0) else begin
                stop_on_error($sformatf("Record %0h came out in %s while none was expected",
                                        rec_out, test_name));
            end
            want = expected_q.pop_front();
            check_value("record", 64'(want), 64'(rec_out));
        end
    end

    // APB has no wait states, so every access phase must see pready high
    always @(posedge pcie_clk) begin
        if (pcie_reset_n && psel && penable) begin
            check_value("pready", 64'd1, 64'(pready));
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge pcie_clk);
        stop_on_error($sformatf("Timeout after %0d cycles in %s", TIMEOUT_CYCLES, test_name));
    end

    initial begin
        pcie_rx_pkg::pkt_meta_t meta;
        logic [31:0]            r;
        logic [31:0]            value;
        logic [7:0]             q;

        pcie_reset_n = 1'b0;
        mmio_write = 1'b0;
        mmio_wr = '0;
        meta_in = '0;
        meta_in_valid = 1'b0;
        rec_out_ready = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        random_stall = 1'b0;
        head_records = 0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(negedge pcie_clk);
        check_value("rec_out_valid", 64'd0, 64'(rec_out_valid));
        check_value("meta_in_ready", 64'd0, 64'(meta_in_ready));
        check_value("disable_pcie", 64'd0, 64'(disable_pcie));
        pcie_reset_n = 1'b1;
        @(negedge pcie_clk);

        test_name = "metadata stream";
        random_stall = 1'b1;
        for (int i = 0; i < NB_META; i++) begin
            meta = random_meta();
            add_expected(expect_record(1'b0, 1'b0, '0, meta));
            send_meta(meta);
        end
        random_stall = 1'b0;
        rec_out_ready = 1'b1;
        wait_drained();

        test_name = "head writes";
        r = next_rand();
        q = r[7:0];
        issue_head(32'(q), PARTIAL_BE);
        issue_head(32'(q) + 32'(pcie_rx_pkg::MAX_NB_FLOWS), HEAD_BE);
        issue_head(32'(q), HEAD_BE);
        wait_drained();

        for (int same = 1; same >= 0; same--) begin
            test_name = (same != 0) ? "merge same queue" : "merge other queue";
            rec_out_ready = 1'b0;
            for (int i = 0; i < FILL_RECORDS; i++) begin
                meta = random_meta();
                add_expected(expect_record(1'b0, 1'b0, '0, meta));
                send_meta(meta);
            end
            // Let the output FIFO settle above half full before the pair arrives
            repeat (2) @(negedge pcie_clk);
            r = next_rand();
            q = r[7:0];
            meta = random_meta();
            meta.pkt_queue_id = (same != 0) ? q : q + 8'd1;
            if (same != 0) begin
                add_expected(expect_record(1'b1, 1'b1, q, meta));
            end else begin
                add_expected(expect_record(1'b1, 1'b0, q, meta));
                add_expected(expect_record(1'b0, 1'b0, '0, meta));
            end
            meta_in = meta;
            meta_in_valid = 1'b1;
            head_write(32'(q), HEAD_BE);
            repeat (4) @(negedge pcie_clk);
            rec_out_ready = 1'b1;
            wait_meta_accept();
            wait_drained();
        end

        test_name = "head flood";
        rec_out_ready = 1'b0;
        for (int i = 0; i < NB_FLOOD; i++) begin
            r = next_rand();
            q = r[7:0];
            if (i < FLOOD_KEPT) begin
                add_expected(expect_record(1'b1, 1'b0, q, '0));
            end
            head_write(32'(q), HEAD_BE);
        end
        repeat (4) @(negedge pcie_clk);
        apb_read(pcie_rx_pkg::IGNORED_CNT_ADDR, value);
        check_value("ignored count", 64'(NB_FLOOD - FLOOD_KEPT), 64'(value));
        rec_out_ready = 1'b1;
        wait_drained();

        test_name = "control registers";
        apb_read(pcie_rx_pkg::HEAD_UPD_CNT_ADDR, value);
        check_value("head update count", 64'(head_records), 64'(value));
        apb_write(pcie_rx_pkg::CTRL_ADDR, 32'd1 << pcie_rx_pkg::DISABLE_BIT);
        check_value("disable_pcie", 64'd1, 64'(disable_pcie));
        apb_read(32'hC, value);
        check_value("unmapped read", 64'd0, 64'(value));
        apb_write(pcie_rx_pkg::CTRL_ADDR, 32'd1 << pcie_rx_pkg::SW_RESET_BIT);
        repeat (3) @(negedge pcie_clk);
        apb_write(pcie_rx_pkg::CTRL_ADDR, 32'd0);
        apb_read(pcie_rx_pkg::IGNORED_CNT_ADDR, value);
        check_value("ignored count after reset", 64'd0, 64'(value));
        apb_read(pcie_rx_pkg::HEAD_UPD_CNT_ADDR, value);
        check_value("head update count after reset", 64'd0, 64'(value));

        repeat (10) @(negedge pcie_clk);
        if (expected_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected records never came out", expected_q.size()));
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+test
hw/pcie_rx_pkg.sv
hw/sync_fifo.sv
hw/head_upd_monitor.sv
hw/rx_meta_merger.sv
hw/ctrl_regs.sv
hw/pcie_rx_top.sv
test/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
